// ==== hdl/id_decoder.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_decoder import id_pkg::*; (
  input  logic [`ID_XLEN-1:0] instr_i,
  output ctrl_word_t          ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];

  // Shared funct3 map for OP and OP-IMM, arith picks SRA
  function automatic alu_op_e f3_alu(input logic [2:0] f3, input logic arith);
    case (f3)
      3'b000:  f3_alu = ALU_ADD;
      3'b001:  f3_alu = ALU_SLL;
      3'b010:  f3_alu = ALU_SLT;
      3'b011:  f3_alu = ALU_SLTU;
      3'b100:  f3_alu = ALU_XOR;
      3'b101:  f3_alu = arith ? ALU_SRA : ALU_SRL;
      3'b110:  f3_alu = ALU_OR;
      default: f3_alu = ALU_AND;
    endcase
  endfunction

  // Branch compare map
  function automatic alu_op_e f3_cmp(input logic [2:0] f3);
    case (f3)
      3'b000:  f3_cmp = ALU_EQ;
      3'b001:  f3_cmp = ALU_NE;
      3'b100:  f3_cmp = ALU_LT;
      3'b101:  f3_cmp = ALU_GE;
      3'b110:  f3_cmp = ALU_LTU;
      default: f3_cmp = ALU_GEU;
    endcase
  endfunction

  always_comb begin
    // Defaults: reg + imm add, nothing enabled
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.op_a_sel = OP_A_REG;
    ctrl_o.op_b_sel = OP_B_IMM;
    ctrl_o.imm_sel  = IMM_I;
    ctrl_o.jt_sel   = JT_JAL;
    ctrl_o.xfer     = XFER_NONE;

    case (opcode)
      `ID_OPC_OP: begin
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.rf_re    = 2'b11;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.alu_op   = (funct7[5] && funct3 == 3'b000) ? ALU_SUB : f3_alu(funct3, funct7[5]);
        // Only SUB and SRA take the alternate funct7
        if (funct7 == 7'h20)
          ctrl_o.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
        else
          ctrl_o.illegal = (funct7 != 7'h00);
      end
      `ID_OPC_OP_IMM: begin
        ctrl_o.rf_re  = 2'b01;
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = f3_alu(funct3, funct7[5]);
        // Shift amounts sit in rs2 field, upper bits constrained
        if (funct3 == 3'b001)
          ctrl_o.illegal = (funct7 != 7'h00);
        else if (funct3 == 3'b101)
          ctrl_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
      end
      `ID_OPC_LUI: begin
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.imm_sel  = IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      `ID_OPC_AUIPC: begin
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.imm_sel  = IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      `ID_OPC_JAL: begin
        // Link value pc + 4 computed in EX
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.imm_sel  = IMM_J;
        ctrl_o.jt_sel   = JT_JAL;
        ctrl_o.xfer     = XFER_JAL;
        ctrl_o.rf_we    = 1'b1;
      end
      `ID_OPC_JALR: begin
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.jt_sel   = JT_JALR;
        ctrl_o.xfer     = XFER_JALR;
        ctrl_o.rf_re    = 2'b01;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.illegal  = (funct3 != 3'b000);
      end
      `ID_OPC_BRANCH: begin
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.imm_sel  = IMM_B;
        ctrl_o.jt_sel   = JT_COND;
        ctrl_o.xfer     = XFER_COND;
        ctrl_o.rf_re    = 2'b11;
        ctrl_o.alu_op   = f3_cmp(funct3);
        ctrl_o.illegal  = (funct3[2:1] == 2'b01);
      end
      `ID_OPC_LOAD: begin
        ctrl_o.rf_re         = 2'b01;
        ctrl_o.rf_we         = 1'b1;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.data_type     = funct3[1:0];
        ctrl_o.data_sign_ext = !funct3[2];
        // LB LH LW LBU LHU only
        ctrl_o.illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      `ID_OPC_STORE: begin
        ctrl_o.imm_sel   = IMM_S;
        ctrl_o.rf_re     = 2'b11;
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.data_type = funct3[1:0];
        ctrl_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: begin
        ctrl_o.illegal = 1'b1;
      end
    endcase

    // Illegal words must not write or touch memory
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.data_req = 1'b0;
      ctrl_o.xfer     = XFER_NONE;
    end

    // x0 stays zero
    if (rd == 5'd0)
      ctrl_o.rf_we = 1'b0;
  end

endmodule

// ==== hdl/id_hazard.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_hazard import id_pkg::*; (
  input  ctrl_word_t           ctrl_i,
  input  logic [`ID_RF_AW-1:0] rs1_i,
  input  logic [`ID_RF_AW-1:0] rs2_i,
  input  wb_bus_t              ex_fwd_i,
  input  wb_bus_t              wb_i,
  input  id_ex_t               id_ex_i,
  output fw_sel_e              fw_a_o,
  output fw_sel_e              fw_b_o,
  output logic                 load_stall_o
);

  logic ld_in_ex;

  // Youngest result wins, x0 never forwarded
  function automatic fw_sel_e fw_pick(input logic [`ID_RF_AW-1:0] rs,
                                      input wb_bus_t ex, input wb_bus_t wb);
    if (rs == '0)
      fw_pick = FW_RF;
    else if (ex.we && ex.waddr == rs)
      fw_pick = FW_EX;
    else if (wb.we && wb.waddr == rs)
      fw_pick = FW_WB;
    else
      fw_pick = FW_RF;
  endfunction

  assign fw_a_o = fw_pick(rs1_i, ex_fwd_i, wb_i);
  assign fw_b_o = fw_pick(rs2_i, ex_fwd_i, wb_i);

  // Load data not ready until WB
  assign ld_in_ex = id_ex_i.valid && id_ex_i.data_req && !id_ex_i.data_we && id_ex_i.rf_we;

  assign load_stall_o = ld_in_ex &&
                        ((ctrl_i.rf_re[0] && rs1_i == id_ex_i.rf_waddr) ||
                         (ctrl_i.rf_re[1] && rs2_i == id_ex_i.rf_waddr));

endmodule

// ==== hdl/id_operands.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_operands import id_pkg::*; (
  input  if_id_t              if_id_i,
  input  ctrl_word_t          ctrl_i,
  input  logic [`ID_XLEN-1:0] rdata_a_i,
  input  logic [`ID_XLEN-1:0] rdata_b_i,
  input  wb_bus_t             ex_fwd_i,
  input  wb_bus_t             wb_i,
  input  fw_sel_e             fw_a_i,
  input  fw_sel_e             fw_b_i,
  output logic [`ID_XLEN-1:0] operand_a_o,
  output logic [`ID_XLEN-1:0] operand_b_o,
  output logic [`ID_XLEN-1:0] operand_c_o,
  output logic [`ID_XLEN-1:0] jump_target_o
);

  logic [`ID_XLEN-1:0] instr;
  logic [`ID_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [`ID_XLEN-1:0] imm;
  logic [`ID_XLEN-1:0] fw_a, fw_b;

  assign instr = if_id_i.instr;

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // All sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////

  always_comb begin
    case (fw_a_i)
      FW_EX:   fw_a = ex_fwd_i.wdata;
      FW_WB:   fw_a = wb_i.wdata;
      default: fw_a = rdata_a_i;
    endcase
    case (fw_b_i)
      FW_EX:   fw_b = ex_fwd_i.wdata;
      FW_WB:   fw_b = wb_i.wdata;
      default: fw_b = rdata_b_i;
    endcase
  end

  // JALR base is the raw register file value, shorter path
  always_comb begin
    case (ctrl_i.jt_sel)
      JT_COND: jump_target_o = if_id_i.pc + imm_b;
      JT_JALR: jump_target_o = rdata_a_i + imm_i;
      default: jump_target_o = if_id_i.pc + imm_j;
    endcase
  end

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = if_id_i.pc;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = fw_a;
    endcase
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = imm;
      OP_B_PCINCR: operand_b_o = `ID_PC_INCR;
      default:     operand_b_o = fw_b;
    endcase
  end

  // Store data or branch rs2, else jump target for EX
  always_comb begin
    if ((ctrl_i.data_req && ctrl_i.data_we) || ctrl_i.xfer == XFER_COND)
      operand_c_o = fw_b;
    else if (ctrl_i.xfer == XFER_JAL || ctrl_i.xfer == XFER_JALR)
      operand_c_o = jump_target_o;
    else
      operand_c_o = '0;
  end

endmodule

// ==== hdl/id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Datapath and register file geometry
`define ID_XLEN      32
`define ID_RF_AW     5
`define ID_RF_DEPTH  32

// RV32I major opcodes
`define ID_OPC_OP      7'h33
`define ID_OPC_OP_IMM  7'h13
`define ID_OPC_LUI     7'h37
`define ID_OPC_AUIPC   7'h17
`define ID_OPC_JAL     7'h6f
`define ID_OPC_JALR    7'h67
`define ID_OPC_BRANCH  7'h63
`define ID_OPC_LOAD    7'h03
`define ID_OPC_STORE   7'h23

// No compressed support, so always a full word
`define ID_PC_INCR  4

`endif

// ==== hdl/id_pkg.sv ====
`include "id_params.svh"

package id_pkg;

  // ALU operation, last six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
  typedef enum logic [1:0] {JT_JAL, JT_COND, JT_JALR} jt_sel_e;
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_COND} xfer_e;

  // Decoder output
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    jt_sel_e    jt_sel;
    xfer_e      xfer;
    logic [1:0] rf_re;          // bit 0 rs1, bit 1 rs2
    logic       rf_we;
    logic       data_req;
    logic       data_we;
    logic [1:0] data_type;      // 00 byte, 01 half, 10 word
    logic       data_sign_ext;
    logic       illegal;
  } ctrl_word_t;

  // IF/ID word
  typedef struct packed {
    logic               instr_valid;
    logic [`ID_XLEN-1:0] pc;
    logic [`ID_XLEN-1:0] instr;
  } if_id_t;

  // Result bus, EX forward and WB write
  typedef struct packed {
    logic                 we;
    logic [`ID_RF_AW-1:0] waddr;
    logic [`ID_XLEN-1:0]  wdata;
  } wb_bus_t;

  // ID/EX pipeline word
  typedef struct packed {
    logic                 valid;
    alu_op_e              alu_op;
    logic [`ID_XLEN-1:0]  operand_a;
    logic [`ID_XLEN-1:0]  operand_b;
    logic [`ID_XLEN-1:0]  operand_c;
    logic                 rf_we;
    logic [`ID_RF_AW-1:0] rf_waddr;
    logic                 data_req;
    logic                 data_we;
    logic [1:0]           data_type;
    logic                 data_sign_ext;
    logic                 branch_in_ex;
    logic [`ID_XLEN-1:0]  pc;
  } id_ex_t;

  // Performance events
  typedef struct packed {
    logic minstret;
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic ld_stall;
  } perf_event_t;

endpackage

// ==== hdl/id_regfile.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_regfile import id_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`ID_RF_AW-1:0] raddr_a_i,
  input  logic [`ID_RF_AW-1:0] raddr_b_i,
  output logic [`ID_XLEN-1:0]  rdata_a_o,
  output logic [`ID_XLEN-1:0]  rdata_b_o,
  input  wb_bus_t              wr_i
);

  // x1..x31 only, x0 is not stored
  logic [`ID_XLEN-1:0] regs [1:`ID_RF_DEPTH-1];

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `ID_RF_DEPTH; i++)
        regs[i] <= '0;
    end else if (wr_i.we && wr_i.waddr != '0) begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Async read, x0 reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage import id_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  if_id_t              if_id_i,
  output logic                id_ready_o,
  input  logic                ex_ready_i,
  input  wb_bus_t             ex_fwd_i,
  input  wb_bus_t             wb_i,
  output id_ex_t              id_ex_o,
  output logic [`ID_XLEN-1:0] jump_target_o,
  output perf_event_t         perf_o
);

  ctrl_word_t           ctrl;
  logic [`ID_RF_AW-1:0] rs1, rs2, rd;
  logic [`ID_XLEN-1:0]  rdata_a, rdata_b;
  logic [`ID_XLEN-1:0]  operand_a, operand_b, operand_c;
  fw_sel_e              fw_a, fw_b;
  logic                 hz_stall;
  logic                 load_stall;
  logic                 id_valid;
  logic                 minstret;
  id_ex_t               id_ex_d;

  // Register fields of the instruction word
  assign rs1 = if_id_i.instr[19:15];
  assign rs2 = if_id_i.instr[24:20];
  assign rd  = if_id_i.instr[11:7];

  id_decoder decoder_i (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl)
  );

  // Only WB writes, EX is forward only
  id_regfile regfile_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wr_i      (wb_i)
  );

  id_hazard hazard_i (
    .ctrl_i       (ctrl),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .ex_fwd_i     (ex_fwd_i),
    .wb_i         (wb_i),
    .id_ex_i      (id_ex_o),
    .fw_a_o       (fw_a),
    .fw_b_o       (fw_b),
    .load_stall_o (hz_stall)
  );

  id_operands operands_i (
    .if_id_i       (if_id_i),
    .ctrl_i        (ctrl),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .ex_fwd_i      (ex_fwd_i),
    .wb_i          (wb_i),
    .fw_a_i        (fw_a),
    .fw_b_i        (fw_b),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jump_target_o (jump_target_o)
  );

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Stall only counts with a real instruction waiting
  assign load_stall = hz_stall && if_id_i.instr_valid;
  assign id_ready_o = ex_ready_i && !load_stall;
  assign id_valid   = if_id_i.instr_valid && id_ready_o;

  // Next ID/EX word
  always_comb begin
    id_ex_d.valid         = 1'b1;
    id_ex_d.alu_op        = ctrl.alu_op;
    id_ex_d.operand_a     = operand_a;
    id_ex_d.operand_b     = operand_b;
    id_ex_d.operand_c     = operand_c;
    id_ex_d.rf_we         = ctrl.rf_we;
    id_ex_d.rf_waddr      = rd;
    id_ex_d.data_req      = ctrl.data_req;
    id_ex_d.data_we       = ctrl.data_we;
    id_ex_d.data_type     = ctrl.data_type;
    id_ex_d.data_sign_ext = ctrl.data_sign_ext;
    id_ex_d.branch_in_ex  = (ctrl.xfer == XFER_COND);
    id_ex_d.pc            = if_id_i.pc;
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (id_valid) begin
      id_ex_o <= id_ex_d;
    end else if (ex_ready_i) begin
      // Bubble, payload left as is
      id_ex_o.valid        <= 1'b0;
      id_ex_o.rf_we        <= 1'b0;
      id_ex_o.data_req     <= 1'b0;
      id_ex_o.branch_in_ex <= 1'b0;
    end
  end

  // Illegal words are issued but never counted
  assign minstret = id_valid && !ctrl.illegal;

  // Event pulses, one cycle after the load edge
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      perf_o <= '0;
    end else begin
      perf_o.minstret <= minstret;
      perf_o.load     <= minstret && ctrl.data_req && !ctrl.data_we;
      perf_o.store    <= minstret && ctrl.data_req && ctrl.data_we;
      perf_o.jump     <= minstret && (ctrl.xfer == XFER_JAL || ctrl.xfer == XFER_JALR);
      perf_o.branch   <= minstret && (ctrl.xfer == XFER_COND);
      perf_o.ld_stall <= load_stall;
    end
  end

endmodule

// ==== id_stage.f ====
+incdir+hdl
+incdir+tests
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_regfile.sv
hdl/id_hazard.sv
hdl/id_operands.sv
hdl/id_stage.sv
tests/tb_id_stage.sv

// ==== tests/tb_id_ref.svh ====
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

// Register mirror, follows the WB writes
logic [`ID_XLEN-1:0] rf_mirror [0:`ID_RF_DEPTH-1];

// RV32I immediate layouts
function automatic logic [31:0] ref_imm_i(input logic [31:0] w);
  return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] ref_imm_s(input logic [31:0] w);
  return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic logic [31:0] ref_imm_b(input logic [31:0] w);
  return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] ref_imm_j(input logic [31:0] w);
  return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// Source value with EX over WB over the register file
function automatic logic [31:0] fwd_value(input logic [4:0] rs, input wb_bus_t ex,
                                          input wb_bus_t wb);
  if (rs == 5'd0)
    return 32'h0;
  if (ex.we && ex.waddr == rs)
    return ex.wdata;
  if (wb.we && wb.waddr == rs)
    return wb.wdata;
  return rf_mirror[rs];
endfunction

function automatic alu_op_e ref_arith(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0: return ALU_ADD;
    3'd1: return ALU_SLL;
    3'd2: return ALU_SLT;
    3'd3: return ALU_SLTU;
    3'd4: return ALU_XOR;
    3'd5: return alt ? ALU_SRA : ALU_SRL;
    3'd6: return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic alu_op_e ref_compare(input logic [2:0] f3);
  case (f3)
    3'd0: return ALU_EQ;
    3'd1: return ALU_NE;
    3'd4: return ALU_LT;
    3'd5: return ALU_GE;
    3'd6: return ALU_LTU;
    default: return ALU_GEU;
  endcase
endfunction

// Which sources an opcode reads
function automatic logic reads_rs1(input logic [6:0] opc);
  return opc == `ID_OPC_OP || opc == `ID_OPC_OP_IMM || opc == `ID_OPC_JALR ||
         opc == `ID_OPC_BRANCH || opc == `ID_OPC_LOAD || opc == `ID_OPC_STORE;
endfunction

function automatic logic reads_rs2(input logic [6:0] opc);
  return opc == `ID_OPC_OP || opc == `ID_OPC_BRANCH || opc == `ID_OPC_STORE;
endfunction

// Load in EX feeding a source of the waiting instruction
function automatic logic ref_stall(input if_id_t f, input id_ex_t prev);
  logic ld;
  ld = prev.valid && prev.data_req && !prev.data_we && prev.rf_we;
  return f.instr_valid && ld &&
         ((reads_rs1(f.instr[6:0]) && f.instr[19:15] == prev.rf_waddr) ||
          (reads_rs2(f.instr[6:0]) && f.instr[24:20] == prev.rf_waddr));
endfunction

function automatic logic [31:0] ref_jump_target(input if_id_t f);
  case (f.instr[6:0])
    `ID_OPC_JALR: begin
      if (f.instr[19:15] == 5'd0)
        return ref_imm_i(f.instr);
      return rf_mirror[f.instr[19:15]] + ref_imm_i(f.instr);
    end
    `ID_OPC_BRANCH: return f.pc + ref_imm_b(f.instr);
    default: return f.pc + ref_imm_j(f.instr);
  endcase
endfunction

function automatic id_ex_t ref_id_ex(input if_id_t f, input wb_bus_t ex, input wb_bus_t wb);
  id_ex_t e;
  logic [31:0] w;
  logic [31:0] v1;
  logic [31:0] v2;
  w = f.instr;
  v1 = fwd_value(w[19:15], ex, wb);
  v2 = fwd_value(w[24:20], ex, wb);
  e = '0;
  e.valid = 1'b1;
  e.alu_op = ALU_ADD;
  e.operand_a = v1;
  e.operand_b = ref_imm_i(w);
  e.rf_waddr = w[11:7];
  e.pc = f.pc;
  case (w[6:0])
    `ID_OPC_OP: begin
      e.operand_b = v2;
      e.alu_op = (w[30] && w[14:12] == 3'd0) ? ALU_SUB : ref_arith(w[14:12], w[30]);
      e.rf_we = 1'b1;
    end
    `ID_OPC_OP_IMM: begin
      e.alu_op = ref_arith(w[14:12], w[30]);
      e.rf_we = 1'b1;
    end
    `ID_OPC_LUI, `ID_OPC_AUIPC: begin
      e.operand_a = (w[6:0] == `ID_OPC_LUI) ? 32'h0 : f.pc;
      e.operand_b = {w[31:12], 12'h0};
      e.rf_we = 1'b1;
    end
    `ID_OPC_JAL, `ID_OPC_JALR: begin
      // Link is pc plus 4, target rides in C
      e.operand_a = f.pc;
      e.operand_b = `ID_PC_INCR;
      e.operand_c = ref_jump_target(f);
      e.rf_we = 1'b1;
    end
    `ID_OPC_BRANCH: begin
      e.operand_b = v2;
      e.operand_c = v2;
      e.alu_op = ref_compare(w[14:12]);
      e.branch_in_ex = 1'b1;
    end
    `ID_OPC_LOAD: begin
      e.rf_we = 1'b1;
      e.data_req = 1'b1;
      e.data_type = w[13:12];
      e.data_sign_ext = !w[14];
    end
    `ID_OPC_STORE: begin
      e.operand_b = ref_imm_s(w);
      e.operand_c = v2;
      e.data_req = 1'b1;
      e.data_we = 1'b1;
      e.data_type = w[13:12];
    end
    default: ;
  endcase
  // No write to x0
  if (w[11:7] == 5'd0)
    e.rf_we = 1'b0;
  return e;
endfunction

function automatic perf_event_t ref_perf(input if_id_t f, input logic issue, input logic stall);
  perf_event_t p;
  logic [6:0] opc;
  logic known;
  opc = f.instr[6:0];
  known = opc == `ID_OPC_OP || opc == `ID_OPC_OP_IMM || opc == `ID_OPC_LUI ||
          opc == `ID_OPC_AUIPC || opc == `ID_OPC_JAL || opc == `ID_OPC_JALR ||
          opc == `ID_OPC_BRANCH || opc == `ID_OPC_LOAD || opc == `ID_OPC_STORE;
  p.minstret = issue && known;
  p.load = p.minstret && opc == `ID_OPC_LOAD;
  p.store = p.minstret && opc == `ID_OPC_STORE;
  p.jump = p.minstret && (opc == `ID_OPC_JAL || opc == `ID_OPC_JALR);
  p.branch = p.minstret && opc == `ID_OPC_BRANCH;
  p.ld_stall = stall;
  return p;
endfunction

`endif

// ==== tests/tb_id_stage.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module tb_id_stage import id_pkg::*; ();

  localparam int NUM_INSTR = 120;
  localparam int INIT_CYCLES = 40;
  localparam int RESET_CYCLES = 8;

  logic clk;
  logic rst_n;
  if_id_t if_id_i;
  logic id_ready_o;
  logic ex_ready_i;
  wb_bus_t ex_fwd_i;
  wb_bus_t wb_i;
  id_ex_t id_ex_o;
  logic [`ID_XLEN-1:0] jump_target_o;
  perf_event_t perf_o;

  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int test_base;
  logic [31:0] pc;
  id_ex_t exp_word;

  `include "tb_id_ref.svh"

  id_stage id_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id_i),
    .id_ready_o    (id_ready_o),
    .ex_ready_i    (ex_ready_i),
    .ex_fwd_i      (ex_fwd_i),
    .wb_i          (wb_i),
    .id_ex_o       (id_ex_o),
    .jump_target_o (jump_target_o),
    .perf_o        (perf_o)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_id_ex(input id_ex_t exp, input id_ex_t act);
    checks++;
    if (act !== exp) begin
      $display("Fail id_ex_o expected %h actual %h", exp, act);
      errors++;
    end
  endtask

  task automatic check_perf(input perf_event_t exp, input perf_event_t act);
    checks++;
    if (act !== exp) begin
      $display("Fail perf_o expected %h actual %h", exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Inputs are stable here, outputs settle 1 ns after the edge
  always @(posedge clk) begin
    id_ex_t nw;
    perf_event_t np;
    logic stall;
    logic ready;
    if (rst_n) begin
      stall = ref_stall(if_id_i, exp_word);
      ready = ex_ready_i && !stall;
      check_bit("id_ready_o", ready, id_ready_o);
      if (if_id_i.instr_valid)
        check_word("jump_target_o", ref_jump_target(if_id_i), jump_target_o);
      if (if_id_i.instr_valid && ready) begin
        nw = ref_id_ex(if_id_i, ex_fwd_i, wb_i);
      end else if (ex_ready_i) begin
        nw = exp_word;
        nw.valid = 1'b0;
        nw.rf_we = 1'b0;
        nw.data_req = 1'b0;
        nw.branch_in_ex = 1'b0;
      end else begin
        nw = exp_word;
      end
      np = ref_perf(if_id_i, if_id_i.instr_valid && ready, stall);
      if (wb_i.we && wb_i.waddr != 5'd0)
        rf_mirror[wb_i.waddr] = wb_i.wdata;
      #1;
      check_id_ex(nw, id_ex_o);
      check_perf(np, perf_o);
      exp_word = nw;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic wb_bus_t bus(input logic we, input logic [4:0] a, input logic [31:0] d);
    return '{we, a, d};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `ID_OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `ID_OPC_JAL};
  endfunction

  // Random legal OP, OP-IMM, LUI or AUIPC
  function automatic logic [31:0] rand_alu();
    logic [31:0] w;
    logic [2:0] f3;
    w = $urandom;
    f3 = w[14:12];
    case ($urandom % 4)
      0: begin
        w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[0]) ? 7'h20 : 7'h00;
        w[6:0] = `ID_OPC_OP;
      end
      1: begin
        if (f3 == 3'd1)
          w[31:25] = 7'h00;
        else if (f3 == 3'd5)
          w[31:25] = w[0] ? 7'h20 : 7'h00;
        w[6:0] = `ID_OPC_OP_IMM;
      end
      2: w[6:0] = `ID_OPC_LUI;
      default: w[6:0] = `ID_OPC_AUIPC;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] rand_mixed();
    logic [31:0] w;
    logic [2:0] ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    w = $urandom;
    case ($urandom % 5)
      0: w = {w[31:15], ld_f3[$urandom % 5], w[11:7], `ID_OPC_LOAD};
      1: w = {w[31:15], 1'b0, 2'($urandom % 3), w[11:7], `ID_OPC_STORE};
      2: w = enc_j(21'($urandom), w[11:7]);
      3: w = enc_b(13'($urandom), w[24:20], w[19:15], br_f3[$urandom % 6]);
      default: w = rand_alu();
    endcase
    return w;
  endfunction

  // Hold the word until accepted, count the edges it took
  task automatic send(input logic [31:0] instr, input wb_bus_t ex, input wb_bus_t wb,
                      output int edges);
    @(negedge clk);
    if_id_i = '{1'b1, pc, instr};
    ex_fwd_i = ex;
    wb_i = wb;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
    end while (!id_ready_o);
    pc = pc + `ID_PC_INCR;
  endtask

  task automatic idle(input int n);
    @(negedge clk);
    if_id_i.instr_valid = 1'b0;
    ex_fwd_i = '0;
    wb_i = '0;
    repeat (n) @(negedge clk);
  endtask

  task automatic test_begin();
    test_base = errors;
    tests_run++;
  endtask

  task automatic test_end(input string name);
    if (errors != test_base)
      tests_failed++;
    $display("Test %0d %s: %0s", tests_run, name, (errors == test_base) ? "ok" : "errors");
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #((NUM_INSTR * 20 + RESET_CYCLES + INIT_CYCLES) * 10);
    $display("Watchdog expired before the tests completed");
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int e;
    id_ex_t held;
    clk = 1'b0;
    rst_n = 1'b0;
    if_id_i = '0;
    ex_ready_i = 1'b1;
    ex_fwd_i = '0;
    wb_i = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    pc = 32'h0000_1000;
    exp_word = '0;
    void'($urandom(32'h90f6));
    for (int i = 0; i < `ID_RF_DEPTH; i++)
      rf_mirror[i] = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Fill the register file through WB
    for (int r = 1; r < `ID_RF_DEPTH; r++) begin
      @(negedge clk);
      wb_i = bus(1'b1, 5'(r), $urandom);
    end
    idle(1);

    test_begin();
    for (int i = 0; i < 40; i++)
      send(rand_alu(), '0, '0, e);
    // Unknown opcode with rd x31
    send(32'hffff_ffff, '0, '0, e);
    idle(1);
    test_end("decode and operands");

    test_begin();
    // add x5, x3, x4 with both buses on x3
    send({7'h00, 5'd4, 5'd3, 3'd0, 5'd5, `ID_OPC_OP}, bus(1'b1, 5'd3, 32'haaaa_0001),
         bus(1'b1, 5'd3, 32'hbbbb_0002), e);
    send({7'h00, 5'd4, 5'd3, 3'd0, 5'd5, `ID_OPC_OP}, '0, bus(1'b1, 5'd4, 32'hcccc_0003), e);
    send({7'h00, 5'd0, 5'd0, 3'd0, 5'd6, `ID_OPC_OP}, bus(1'b1, 5'd0, 32'hdead_beef),
         bus(1'b1, 5'd0, 32'hfeed_f00d), e);
    idle(1);
    test_end("forwarding");

    test_begin();
    for (int i = 0; i < 5; i++) begin
      send(enc_j(21'($urandom), 5'($urandom)), '0, '0, e);
      // JALR with EX forwarding rs1, target keeps the RF value
      send({12'($urandom), 5'd9, 3'd0, 5'd1, `ID_OPC_JALR}, bus(1'b1, 5'd9, $urandom), '0, e);
      send(enc_b(13'($urandom), 5'd10, 5'd11, 3'd5), bus(1'b1, 5'd10, $urandom), '0, e);
    end
    idle(1);
    test_end("jumps and branches");

    test_begin();
    // lw x7, 0(x2) then add x8, x7, x1
    send({12'h0, 5'd2, 3'd2, 5'd7, `ID_OPC_LOAD}, '0, '0, e);
    send({7'h00, 5'd1, 5'd7, 3'd0, 5'd8, `ID_OPC_OP}, '0, bus(1'b1, 5'd7, 32'h1234_5678), e);
    if (e != 2) begin
      $display("Load-use stall lasted %0d cycles instead of one", e - 1);
      errors++;
    end
    idle(1);
    test_end("load-use stall");

    test_begin();
    @(negedge clk);
    held = exp_word;
    ex_ready_i = 1'b0;
    if_id_i = '{1'b1, pc, rand_alu()};
    repeat (4) @(negedge clk);
    check_id_ex(held, id_ex_o);
    ex_ready_i = 1'b1;
    @(posedge clk);
    pc = pc + `ID_PC_INCR;
    idle(1);
    test_end("EX back-pressure");

    test_begin();
    for (int i = 0; i < 30; i++)
      send(rand_mixed(), bus(1'($urandom), 5'($urandom), $urandom),
           bus(1'($urandom), 5'($urandom), $urandom), e);
    idle(3);
    test_end("performance events");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
